//--- board_pkg.sv
`default_nettype none

package board_pkg;

	// GPIO pad bank
	localparam int PIN_COUNT = 12;

	// Internal reset stretch after reset2a falls
	localparam int RESET_HOLD_CYCLES = 16;
	localparam int HOLD_CNT_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);
	localparam logic [HOLD_CNT_WIDTH-1:0] HOLD_CNT_DONE = HOLD_CNT_WIDTH'(RESET_HOLD_CYCLES);

	// Register map, words 4 to 15 are scratch
	localparam logic [3:0] ADDR_PIN_OUT    = 4'd0;	// Pad output values
	localparam logic [3:0] ADDR_PIN_DIR    = 4'd1;	// 1 = pad driven
	localparam logic [3:0] ADDR_PIN_IN     = 4'd2;	// Last sampled pad state
	localparam logic [3:0] ADDR_EDGE_COUNT = 4'd3;	// Pad change counter

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int ADDR_WIDTH = 4;
	localparam int REG_COUNT  = 1 << ADDR_WIDTH;

	// Host opcodes, 2'b11 falls back to a read
	localparam logic [1:0] OP_READ   = 2'd0;
	localparam logic [1:0] OP_WRITE  = 2'd1;
	localparam logic [1:0] OP_PINCFG = 2'd2;

	// Arbiter requester indices
	localparam logic REQ_HOST    = 1'b0;
	localparam logic REQ_SAMPLER = 1'b1;

	// Arbiter states
	localparam logic [1:0] ARB_IDLE    = 2'd0;
	localparam logic [1:0] ARB_ACCESS  = 2'd1;	// Regfile strobe cycle
	localparam logic [1:0] ARB_ACK     = 2'd2;	// Capture read data, raise ack
	localparam logic [1:0] ARB_RELEASE = 2'd3;	// Wait for req to drop

	// Four-phase master states, host port and sampler
	localparam logic [1:0] HS_IDLE = 2'd0;
	localparam logic [1:0] HS_REQ  = 2'd1;	// req high, waiting for ack
	localparam logic [1:0] HS_DROP = 2'd2;	// req low, waiting for ack low
	localparam logic [1:0] HS_DONE = 2'd3;	// Host ack high

	// Host command word, same opcode bits in both views
	typedef union packed {
		struct packed {
			logic [1:0]            opcode;
			logic [9:0]            rsvd;
			logic [ADDR_WIDTH-1:0] addr;
			logic [DATA_WIDTH-1:0] data;
		} mem;
		struct packed {
			logic [1:0]  opcode;
			logic [5:0]  rsvd;
			logic [11:0] dir_mask;	// Set bit drives the pad
			logic [11:0] out_val;
		} pin;
	} host_cmd_u;

endpackage

`default_nettype wire

//--- reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import board_pkg::*;
(
	input  wire  clock_50mhz,
	input  wire  reset2a,		// External reset, active high
	output logic sys_reset_o	// Stretched internal reset
);

	logic [HOLD_CNT_WIDTH-1:0] hold_cnt;	// Sanity count since release

	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			hold_cnt    <= '0;
			sys_reset_o <= 1'b1;
		end
		else
		begin
			// Count up once, then park at the limit
			if (hold_cnt != HOLD_CNT_DONE)
			begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			sys_reset_o <= (hold_cnt != HOLD_CNT_DONE);	// Released only at the limit
		end
	end

	// External reset always reaches the core one cycle later
	a_reset_follows: assert property (
		@(posedge clock_50mhz) reset2a |=> sys_reset_o
	);

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import bus_pkg::*;
(
	input  wire                   clock_50mhz,
	input  wire                   sys_reset_i,
	input  wire                   host_req_i,
	input  wire                   host_we_i,
	input  wire  [ADDR_WIDTH-1:0] host_addr_i,
	input  wire  [DATA_WIDTH-1:0] host_wdata_i,
	output logic                  host_ack_o,
	input  wire                   smp_req_i,
	input  wire                   smp_we_i,
	input  wire  [ADDR_WIDTH-1:0] smp_addr_i,
	input  wire  [DATA_WIDTH-1:0] smp_wdata_i,
	output logic                  smp_ack_o,
	output logic                  rf_strobe_o,
	output logic                  rf_we_o,
	output logic [ADDR_WIDTH-1:0] rf_addr_o,
	output logic [DATA_WIDTH-1:0] rf_wdata_o,
	input  wire  [DATA_WIDTH-1:0] rf_rdata_i,
	output logic [DATA_WIDTH-1:0] rdata_o
);

	logic [1:0] state;
	logic       sel;			// Granted requester
	logic       last_served;	// Round robin memory
	logic       sel_req;

	// Mux the granted peer onto the regfile
	assign sel_req     = (sel == REQ_SAMPLER) ? smp_req_i : host_req_i;
	assign rf_strobe_o = (state == ARB_ACCESS);	// Exactly one cycle per grant
	assign rf_we_o     = (sel == REQ_SAMPLER) ? smp_we_i : host_we_i;
	assign rf_addr_o   = (sel == REQ_SAMPLER) ? smp_addr_i : host_addr_i;
	assign rf_wdata_o  = (sel == REQ_SAMPLER) ? smp_wdata_i : host_wdata_i;

	always_ff @(posedge clock_50mhz)
	begin
		if (sys_reset_i)
		begin
			state       <= ARB_IDLE;
			sel         <= REQ_HOST;
			last_served <= REQ_SAMPLER;	// Host wins the first tie
			host_ack_o  <= 1'b0;
			smp_ack_o   <= 1'b0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					if (host_req_i && smp_req_i)
					begin
						sel   <= ~last_served;	// Tie goes to the peer not served last
						state <= ARB_ACCESS;
					end
					else if (host_req_i || smp_req_i)
					begin
						sel   <= smp_req_i ? REQ_SAMPLER : REQ_HOST;
						state <= ARB_ACCESS;
					end
				end
				ARB_ACCESS: state <= ARB_ACK;
				ARB_ACK:
				begin
					host_ack_o  <= (sel == REQ_HOST);	// Only the granted peer
					smp_ack_o   <= (sel == REQ_SAMPLER);
					last_served <= sel;
					state       <= ARB_RELEASE;
				end
				default:
				begin
					if (!sel_req)	// Peer saw ack and let go
					begin
						host_ack_o <= 1'b0;
						smp_ack_o  <= 1'b0;
						state      <= ARB_IDLE;
					end
				end
			endcase
		end
	end

	// Read word lands from the regfile one cycle after strobe
	always_ff @(posedge clock_50mhz)
	begin
		if (state == ARB_ACK)
		begin
			rdata_o <= rf_rdata_i;
		end
	end

	a_one_ack: assert property (@(posedge clock_50mhz) disable iff (sys_reset_i)
		!(host_ack_o && smp_ack_o));
	a_host_ack_req: assert property (@(posedge clock_50mhz) disable iff (sys_reset_i)
		$rose(host_ack_o) |-> host_req_i);
	a_smp_ack_req: assert property (@(posedge clock_50mhz) disable iff (sys_reset_i)
		$rose(smp_ack_o) |-> smp_req_i);

endmodule

`default_nettype wire

//--- mmio_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_regfile import board_pkg::*, bus_pkg::*;
(
	input  wire                   clock_50mhz,
	input  wire                   sys_reset_i,
	input  wire                   strobe_i,		// One cycle per access
	input  wire                   we_i,
	input  wire  [ADDR_WIDTH-1:0] addr_i,
	input  wire  [DATA_WIDTH-1:0] wdata_i,
	output logic [DATA_WIDTH-1:0] rdata_o,		// Valid the cycle after strobe
	output logic [PIN_COUNT-1:0]  pin_out_o,
	output logic [PIN_COUNT-1:0]  pin_dir_o
);

	logic [DATA_WIDTH-1:0] mem [0:REG_COUNT-1];

	// Whole map comes up zero, so the pads start released
	always_ff @(posedge clock_50mhz)
	begin
		if (sys_reset_i)
		begin
			for (int i = 0; i < REG_COUNT; i++)
			begin
				mem[i] <= '0;
			end
			rdata_o <= '0;
		end
		else if (strobe_i)
		begin
			if (we_i)
			begin
				mem[addr_i] <= wdata_i;
			end
			rdata_o <= mem[addr_i];	// Old word on a write
		end
	end

	// Low bits of words 0 and 1 go straight to the pads
	assign pin_out_o = mem[ADDR_PIN_OUT][PIN_COUNT-1:0];
	assign pin_dir_o = mem[ADDR_PIN_DIR][PIN_COUNT-1:0];

endmodule

`default_nettype wire

//--- host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port import board_pkg::*, bus_pkg::*;
(
	input  wire                   clock_50mhz,
	input  wire                   sys_reset_i,
	input  wire                   req_i,
	input  wire  host_cmd_u       cmd_i,
	output logic                  ack_o,
	output logic [DATA_WIDTH-1:0] rdata_o,
	output logic                  bus_req_o,
	output logic                  bus_we_o,
	output logic [ADDR_WIDTH-1:0] bus_addr_o,
	output logic [DATA_WIDTH-1:0] bus_wdata_o,
	input  wire                   bus_ack_i,
	input  wire  [DATA_WIDTH-1:0] bus_rdata_i
);

	logic [1:0] state;
	host_cmd_u  cmd_q;		// Command held for the whole transaction
	logic       second;		// Direction write of a pin config
	logic       is_pincfg;

	assign is_pincfg = (cmd_q.mem.opcode == OP_PINCFG);
	assign bus_we_o  = (cmd_q.mem.opcode == OP_WRITE) || is_pincfg;

	// Pin view splits into two accesses, memory view into one
	assign bus_addr_o  = is_pincfg ? (second ? ADDR_PIN_DIR : ADDR_PIN_OUT) : cmd_q.mem.addr;
	assign bus_wdata_o = !is_pincfg ? cmd_q.mem.data
		: second ? DATA_WIDTH'(cmd_q.pin.dir_mask) : DATA_WIDTH'(cmd_q.pin.out_val);

	always_ff @(posedge clock_50mhz)
	begin
		if (sys_reset_i)
		begin
			state     <= HS_IDLE;
			second    <= 1'b0;
			bus_req_o <= 1'b0;
			ack_o     <= 1'b0;
			rdata_o   <= '0;
		end
		else
		begin
			case (state)
				HS_IDLE:
				begin
					if (req_i)
					begin
						cmd_q     <= cmd_i;
						second    <= 1'b0;
						rdata_o   <= '0;	// Writes answer zero
						bus_req_o <= 1'b1;
						state     <= HS_REQ;
					end
				end
				HS_REQ:
				begin
					if (bus_ack_i)
					begin
						if (!bus_we_o)
						begin
							rdata_o <= bus_rdata_i;
						end
						bus_req_o <= 1'b0;
						state     <= HS_DROP;
					end
				end
				HS_DROP:
				begin
					if (!bus_ack_i && is_pincfg && !second)
					begin
						second    <= 1'b1;	// Now the direction mask
						bus_req_o <= 1'b1;
						state     <= HS_REQ;
					end
					else if (!bus_ack_i)
					begin
						ack_o <= 1'b1;	// Last access closed
						state <= HS_DONE;
					end
				end
				default:
				begin
					if (!req_i)
					begin
						ack_o <= 1'b0;
						state <= HS_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pin_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module pin_sampler import board_pkg::*, bus_pkg::*;
(
	input  wire                   clock_50mhz,
	input  wire                   sys_reset_i,
	input  wire  [PIN_COUNT-1:0]  pins_i,		// Raw pad values
	output logic                  bus_req_o,
	output logic                  bus_we_o,
	output logic [ADDR_WIDTH-1:0] bus_addr_o,
	output logic [DATA_WIDTH-1:0] bus_wdata_o,
	input  wire                   bus_ack_i
);

	logic [PIN_COUNT-1:0]  sync1;
	logic [PIN_COUNT-1:0]  sync2;
	logic [PIN_COUNT-1:0]  last_val;	// Last state reported to the map
	logic [DATA_WIDTH-1:0] edge_cnt;
	logic [1:0]            state;
	logic                  second;		// Count write pending

	// Two-flop synchronizer, free running
	always_ff @(posedge clock_50mhz)
	begin
		sync1 <= pins_i;
		sync2 <= sync1;
	end

	assign bus_we_o    = 1'b1;	// Sampler only writes
	assign bus_addr_o  = second ? ADDR_EDGE_COUNT : ADDR_PIN_IN;
	assign bus_wdata_o = second ? edge_cnt : DATA_WIDTH'(last_val);

	always_ff @(posedge clock_50mhz)
	begin
		if (sys_reset_i)
		begin
			last_val  <= '0;
			edge_cnt  <= '0;
			second    <= 1'b0;
			bus_req_o <= 1'b0;
			state     <= HS_IDLE;
		end
		else
		begin
			case (state)
				HS_IDLE:
				begin
					// Changes during a pending write are caught here later
					if (sync2 != last_val)
					begin
						last_val  <= sync2;
						edge_cnt  <= edge_cnt + 1'b1;
						second    <= 1'b0;
						bus_req_o <= 1'b1;
						state     <= HS_REQ;
					end
				end
				HS_REQ:
				begin
					if (bus_ack_i)
					begin
						bus_req_o <= 1'b0;
						state     <= HS_DROP;
					end
				end
				default:
				begin
					if (!bus_ack_i)
					begin
						second    <= ~second;
						bus_req_o <= ~second;	// Count write follows pin write
						state     <= second ? HS_IDLE : HS_REQ;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top import board_pkg::*, bus_pkg::*;
(
	input  wire                   clock_50mhz,
	input  wire                   reset2a,
	input  wire                   req_i,
	input  wire  host_cmd_u       cmd_i,
	output logic                  ack_o,
	output logic [DATA_WIDTH-1:0] rdata_o,
	inout  wire  [PIN_COUNT-1:0]  gpio_pins
);

	logic                  sys_reset;
	logic [PIN_COUNT-1:0]  pin_out;
	logic [PIN_COUNT-1:0]  pin_dir;
	logic [PIN_COUNT-1:0]  pins_in;
	logic                  host_req, host_we, host_ack;
	logic [ADDR_WIDTH-1:0] host_addr;
	logic [DATA_WIDTH-1:0] host_wdata;
	logic                  smp_req, smp_we, smp_ack;
	logic [ADDR_WIDTH-1:0] smp_addr;
	logic [DATA_WIDTH-1:0] smp_wdata;
	logic                  rf_strobe, rf_we;
	logic [ADDR_WIDTH-1:0] rf_addr;
	logic [DATA_WIDTH-1:0] rf_wdata, rf_rdata, arb_rdata;

	// Pads, the only place a z exists
	for (genvar i = 0; i < PIN_COUNT; i++)
	begin : g_pad
		assign gpio_pins[i] = pin_dir[i] ? pin_out[i] : 1'bz;
	end
	assign pins_in = gpio_pins;	// Driven pins read back their own value

	reset_sequencer i_reset_sequencer (.clock_50mhz(clock_50mhz), .reset2a(reset2a),
		.sys_reset_o(sys_reset));

	host_port i_host_port (.clock_50mhz(clock_50mhz), .sys_reset_i(sys_reset),
		.req_i(req_i), .cmd_i(cmd_i), .ack_o(ack_o), .rdata_o(rdata_o),
		.bus_req_o(host_req), .bus_we_o(host_we), .bus_addr_o(host_addr),
		.bus_wdata_o(host_wdata), .bus_ack_i(host_ack), .bus_rdata_i(arb_rdata));

	pin_sampler i_pin_sampler (.clock_50mhz(clock_50mhz), .sys_reset_i(sys_reset),
		.pins_i(pins_in), .bus_req_o(smp_req), .bus_we_o(smp_we), .bus_addr_o(smp_addr),
		.bus_wdata_o(smp_wdata), .bus_ack_i(smp_ack));

	bus_arbiter i_bus_arbiter (.clock_50mhz(clock_50mhz), .sys_reset_i(sys_reset),
		.host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
		.host_wdata_i(host_wdata), .host_ack_o(host_ack),
		.smp_req_i(smp_req), .smp_we_i(smp_we), .smp_addr_i(smp_addr),
		.smp_wdata_i(smp_wdata), .smp_ack_o(smp_ack),
		.rf_strobe_o(rf_strobe), .rf_we_o(rf_we), .rf_addr_o(rf_addr),
		.rf_wdata_o(rf_wdata), .rf_rdata_i(rf_rdata), .rdata_o(arb_rdata));

	mmio_regfile i_mmio_regfile (.clock_50mhz(clock_50mhz), .sys_reset_i(sys_reset),
		.strobe_i(rf_strobe), .we_i(rf_we), .addr_i(rf_addr), .wdata_i(rf_wdata),
		.rdata_o(rf_rdata), .pin_out_o(pin_out), .pin_dir_o(pin_dir));

endmodule

`default_nettype wire

//--- tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_top import board_pkg::*, bus_pkg::*;
();

	localparam int SETTLE      = 20;	// Idle wait before pin reads
	localparam int PIN_ROUNDS  = 6;
	localparam int LOAD_CMDS   = 40;
	localparam int INJECTS     = 5;
	localparam int INJECT_GAP  = 48;	// Far enough apart that each change is counted
	localparam int CFG_ROUNDS  = 4;
	localparam int TXN_WORST   = 40;	// Pin config beside a busy sampler
	localparam int TXN_TOTAL   = REG_COUNT + 24 + 2 * PIN_ROUNDS + LOAD_CMDS + 2 + 4 * CFG_ROUNDS;
	localparam int WAIT_TOTAL  = 3 + RESET_HOLD_CYCLES + SETTLE * (PIN_ROUNDS + 1 + CFG_ROUNDS)
		+ INJECTS * INJECT_GAP + CFG_ROUNDS;
	localparam int CYCLE_LIMIT = 2 * (TXN_TOTAL * TXN_WORST + WAIT_TOTAL);

	logic                  clock_50mhz;
	logic                  reset2a;
	logic                  req_i;
	host_cmd_u             cmd_i;
	wire                   ack_o;
	wire  [DATA_WIDTH-1:0] rdata_o;
	wire  [PIN_COUNT-1:0]  gpio_pins;
	logic [PIN_COUNT-1:0]  tb_drv;		// Levels put on input pads
	logic [PIN_COUNT-1:0]  tb_en;		// Per pad driver enable
	logic [PIN_COUNT-1:0]  pin_out_m;
	logic [PIN_COUNT-1:0]  pin_dir_m;
	logic [PIN_COUNT-1:0]  out_v;
	logic [PIN_COUNT-1:0]  dir_v;
	logic [PIN_COUNT-1:0]  going_out;
	logic [PIN_COUNT-1:0]  going_in;
	logic [DATA_WIDTH-1:0] shadow [0:REG_COUNT-1];	// Expected register map
	logic [DATA_WIDTH-1:0] exp_q [$];
	logic [ADDR_WIDTH-1:0] addr_q [$];
	logic [DATA_WIDTH-1:0] exp_v;
	logic [ADDR_WIDTH-1:0] addr_v;
	logic [ADDR_WIDTH-1:0] order [0:11];
	logic [ADDR_WIDTH-1:0] tmp_addr;
	logic [ADDR_WIDTH-1:0] load_addr;
	logic                  ack_seen;
	int                    edge_exp;	// Distinct pad changes applied
	int                    j;
	int                    data_errors;
	int                    other_errors;
	int                    cycles;

	board_top i_board_top (.clock_50mhz(clock_50mhz), .reset2a(reset2a), .req_i(req_i),
		.cmd_i(cmd_i), .ack_o(ack_o), .rdata_o(rdata_o), .gpio_pins(gpio_pins));

	// Testbench side of each pad
	for (genvar i = 0; i < PIN_COUNT; i++)
	begin : g_drv
		assign gpio_pins[i] = tb_en[i] ? tb_drv[i] : 1'bz;
	end

	always #10 clock_50mhz = ~clock_50mhz;

	// Pad word as the sampler should see it
	function automatic logic [PIN_COUNT-1:0] model_pins(input logic [PIN_COUNT-1:0] out_w,
		input logic [PIN_COUNT-1:0] dir_w, input logic [PIN_COUNT-1:0] ext_w);
		return (out_w & dir_w) | (ext_w & ~dir_w);
	endfunction

	// New random level on input pads, always a real change
	function automatic logic [PIN_COUNT-1:0] next_pad_value(input logic [PIN_COUNT-1:0] dir_w,
		input logic [PIN_COUNT-1:0] cur);
		logic [PIN_COUNT-1:0] v;
		v = (PIN_COUNT'($urandom) & ~dir_w) | (cur & dir_w);
		if (v == cur)
		begin
			v[0] = ~v[0];	// Bit 0 is never an output here
		end
		return v;
	endfunction

	task automatic tick(input int n);
		repeat (n)
		begin
			@(posedge clock_50mhz);
			#1;
		end
	endtask

	// Four-phase host access, expected data queued for the checker
	task automatic host_txn(input host_cmd_u cmd, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] expected);
		while (ack_o)
		begin
			tick(1);
		end
		exp_q.push_back(expected);
		addr_q.push_back(addr);
		cmd_i = cmd;
		req_i = 1'b1;
		tick(1);
		while (!ack_o)
		begin
			tick(1);
		end
		req_i = 1'b0;
		while (ack_o)
		begin
			tick(1);
		end
	endtask

	task automatic mem_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		host_cmd_u cmd;
		cmd = '0;
		cmd.mem.opcode = OP_WRITE;
		cmd.mem.addr   = addr;
		cmd.mem.data   = data;
		shadow[addr]   = data;
		host_txn(cmd, addr, '0);	// Writes answer zero
	endtask

	task automatic mem_read(input logic [ADDR_WIDTH-1:0] addr);
		host_cmd_u cmd;
		cmd = '0;
		cmd.mem.opcode = OP_READ;
		cmd.mem.addr   = addr;
		host_txn(cmd, addr, shadow[addr]);
	endtask

	task automatic pin_config(input logic [PIN_COUNT-1:0] out_w, input logic [PIN_COUNT-1:0] dir_w);
		host_cmd_u cmd;
		cmd = '0;
		cmd.pin.opcode   = OP_PINCFG;
		cmd.pin.out_val  = out_w;
		cmd.pin.dir_mask = dir_w;
		shadow[ADDR_PIN_OUT] = DATA_WIDTH'(out_w);
		shadow[ADDR_PIN_DIR] = DATA_WIDTH'(dir_w);
		pin_out_m = out_w;
		pin_dir_m = dir_w;
		host_txn(cmd, ADDR_PIN_DIR, '0);
	endtask

	task automatic check_pin_words(input bit with_count);
		shadow[ADDR_PIN_IN] = DATA_WIDTH'(model_pins(pin_out_m, pin_dir_m, tb_drv));
		mem_read(ADDR_PIN_IN);
		if (with_count)
		begin
			shadow[ADDR_EDGE_COUNT] = DATA_WIDTH'(edge_exp);
			mem_read(ADDR_EDGE_COUNT);
		end
	endtask

	// Checker, one queued expectation per rising host ack
	always @(posedge clock_50mhz)
	begin
		ack_seen <= ack_o;
		if (ack_o && !ack_seen)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				other_errors++;
				$display("Host ack arrived with no transaction outstanding at %0t", $time);
			end
			if (exp_q.size() != 0)
			begin
				exp_v  = exp_q.pop_front();
				addr_v = addr_q.pop_front();
				assert (rdata_o == exp_v)
				else
				begin
					data_errors++;
					$display("ERR %0t: addr %0d returned %h, expected %h", $time, addr_v,
						rdata_o, exp_v);
				end
			end
		end
	end

	always @(posedge clock_50mhz)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		clock_50mhz  = 1'b0;
		reset2a      = 1'b1;
		req_i        = 1'b0;
		cmd_i        = '0;
		tb_en        = '1;	// All pads are inputs out of reset
		tb_drv       = '0;
		pin_out_m    = '0;
		pin_dir_m    = '0;
		edge_exp     = 0;
		ack_seen     = 1'b0;
		data_errors  = 0;
		other_errors = 0;
		cycles       = 0;
		for (int i = 0; i < REG_COUNT; i++)
		begin
			shadow[i] = '0;
		end
		void'($urandom(32'h9e16_7efa));

		// Reset, then the hold window with a request left hanging
		tick(3);
		reset2a = 1'b0;
		req_i   = 1'b1;	// Core still in reset, so no answer
		for (int i = 0; i < RESET_HOLD_CYCLES; i++)
		begin
			tick(1);
			assert (!ack_o && i_board_top.pin_dir == '0)
			else
			begin
				other_errors++;
				$display("Host ack or a pad driver came up during the reset hold at %0t", $time);
			end
		end
		req_i = 1'b0;
		tick(1);
		for (int i = 0; i < REG_COUNT; i++)
		begin
			mem_read(ADDR_WIDTH'(i));
		end

		// Scratch words, read back shuffled
		for (int i = 4; i < REG_COUNT; i++)
		begin
			mem_write(ADDR_WIDTH'(i), DATA_WIDTH'($urandom));
		end
		for (int i = 0; i < 12; i++)
		begin
			order[i] = ADDR_WIDTH'(i + 4);
		end
		for (int i = 11; i > 0; i--)
		begin
			j        = int'($urandom_range(i));
			tmp_addr = order[i];
			order[i] = order[j];
			order[j] = tmp_addr;
		end
		for (int i = 0; i < 12; i++)
		begin
			mem_read(order[i]);
		end

		// Pin sampling with the host idle
		for (int r = 0; r < PIN_ROUNDS; r++)
		begin
			tb_drv = next_pad_value(pin_dir_m, tb_drv);
			edge_exp++;
			tick(SETTLE);
			check_pin_words(1'b1);
		end

		// Host traffic with pad changes injected
		fork
			begin
				for (int c = 0; c < LOAD_CMDS; c++)
				begin
					load_addr = ADDR_WIDTH'(4 + $urandom_range(11));
					if ($urandom_range(1) == 0)
					begin
						mem_write(load_addr, DATA_WIDTH'($urandom));
					end
					else
					begin
						mem_read(load_addr);
					end
				end
			end
			begin
				for (int k = 0; k < INJECTS; k++)
				begin
					tick(INJECT_GAP);
					tb_drv = next_pad_value(pin_dir_m, tb_drv);
					edge_exp++;
				end
			end
		join
		tick(SETTLE);
		check_pin_words(1'b1);

		// Pin config, count no longer tracked from here
		for (int r = 0; r < CFG_ROUNDS; r++)
		begin
			out_v     = PIN_COUNT'($urandom);
			dir_v     = PIN_COUNT'($urandom) & {{(PIN_COUNT-1){1'b1}}, 1'b0};
			going_out = dir_v & ~pin_dir_m;
			going_in  = pin_dir_m & ~dir_v;
			tb_drv    = (tb_drv & ~going_out) | (out_v & going_out);	// Same level as the DUT
			pin_config(out_v, dir_v);
			tb_en  = ~dir_v;
			tb_drv = (tb_drv & ~going_in) | (PIN_COUNT'($urandom) & going_in);
			tick(1);
			assert ((gpio_pins & dir_v) == (out_v & dir_v))
			else
			begin
				data_errors++;
				$display("ERR %0t: pads %h, expected %h on driven mask %h", $time, gpio_pins,
					out_v & dir_v, dir_v);
			end
			tick(SETTLE);
			mem_read(ADDR_PIN_OUT);
			mem_read(ADDR_PIN_DIR);
			check_pin_words(1'b0);
		end

		tick(2);
		$display("Errors: %0d data, %0d other", data_errors, other_errors);
		if (data_errors + other_errors == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
board_pkg.sv
bus_pkg.sv
reset_sequencer.sv
bus_arbiter.sv
mmio_regfile.sv
host_port.sv
pin_sampler.sv
board_top.sv
tb_board_top.sv

//--- Makefile
# Verilator build and run of the board top testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
